// File: Makefile
# Verilator build, run and lint for the lockstep checker

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f compile.f --top-module tb_lockstep

# The run passes only when the pass message shows in the output
run: build
	@out="$$(./obj_dir/Vtb_lockstep)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

lint:
	verilator --lint-only --timing -f compile.f --top-module lockstep_top

clean:
	rm -rf obj_dir

// File: compile.f
rtl/lockstep_pkg.sv
rtl/shadow_reset_ctrl.sv
rtl/input_delay_line.sv
rtl/accum_core.sv
rtl/output_compare.sv
rtl/lockstep_top.sv
dv/tb_clk_gen.sv
dv/tb_lockstep.sv

// File: dv/tb_clk_gen.sv
// Clock source for the lockstep testbench.
// Starts low and toggles every half period, giving a 20 ns period.

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o
);

  localparam int unsigned HALF_PERIOD_NS = 10;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// File: dv/tb_lockstep.sv
// Testbench for the lockstep checker.
// Models the main core, applies a table of instructions with optional faults
// on the main outputs and checks both alerts through an expected-value pipeline.

`timescale 1ns/1ps
`default_nettype none

module tb_lockstep;

  import lockstep_pkg::*;

  localparam int                RESET_CYCLES  = 4;
  localparam int                RANDOM_ROWS   = 64;
  localparam int                DRAIN_TIMEOUT = 16;
  localparam int                CORRUPT_BIT   = 5;
  localparam logic [DATA_W-1:0] LFSR_SEED     = 16'd59;
  localparam logic [DATA_W-1:0] LFSR_TAPS     = 16'hB400;

  typedef struct packed {
    logic              valid;
    logic [OP_W-1:0]   opcode;
    logic [DATA_W-1:0] operand;
    logic              corrupt_acc;
    logic              corrupt_valid;
    logic              exp_major;
    logic              exp_minor;
  } row_t;

  typedef struct packed {
    logic valid;
    logic major;
    logic minor;
  } exp_t;

  logic              clk;
  logic              rst_n;
  core_in_t          core_in;
  core_out_t         core_out;
  logic              alert_major;
  logic              alert_minor;

  row_t              table_q[$];
  exp_t              pipe_q [OUTPUTS_OFFSET];
  row_t              cur_row;
  logic              cur_real;
  logic [DATA_W-1:0] main_acc;
  logic [DATA_W-1:0] lfsr_q;

  tb_clk_gen u_clk_gen (
    .clk_o(clk)
  );

  lockstep_top u_dut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .core_in_i    (core_in),
    .core_out_i   (core_out),
    .alert_major_o(alert_major),
    .alert_minor_o(alert_minor)
  );

  //////////////////////////////////////////////////
  // Random source and table building
  //////////////////////////////////////////////////

  function automatic logic [DATA_W-1:0] lfsr_next(input logic [DATA_W-1:0] state);
    logic [DATA_W-1:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ LFSR_TAPS;
    end
    return next;
  endfunction

  task automatic draw_bits(input int unsigned n, output logic [DATA_W-1:0] value);
    value = '0;
    for (int unsigned i = 0; i < n; i++) begin
      value  = {value[DATA_W-2:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  function automatic logic is_legal(input logic [OP_W-1:0] op);
    return op inside {OP_CLR, OP_LOAD, OP_ADD, OP_SUB, OP_XOR};
  endfunction

  task automatic add_row(input logic valid, input logic [OP_W-1:0] op,
                         input logic [DATA_W-1:0] operand,
                         input logic c_acc, input logic c_valid);
    row_t row;
    row.valid         = valid;
    row.opcode        = op;
    row.operand       = operand;
    row.corrupt_acc   = c_acc;
    row.corrupt_valid = c_valid;
    // Any flipped main output bit must differ from the shadow
    row.exp_major     = c_acc | c_valid;
    row.exp_minor     = valid & ~is_legal(op);
    table_q.push_back(row);
  endtask

  // Idle rows with random opcode and operand, instr_valid low
  task automatic add_fillers(input int count);
    logic [DATA_W-1:0] op_bits;
    logic [DATA_W-1:0] operand;
    for (int i = 0; i < count; i++) begin
      draw_bits(OP_W, op_bits);
      draw_bits(DATA_W, operand);
      add_row(1'b0, op_bits[OP_W-1:0], operand, 1'b0, 1'b0);
    end
  endtask

  task automatic build_table();
    logic [DATA_W-1:0] bits;
    logic [DATA_W-1:0] operand;
    logic [OP_W-1:0]   op;
    logic              valid;
    add_fillers(3);
    // Wraparound in both directions
    add_row(1'b1, OP_LOAD, 16'hFFF0, 1'b0, 1'b0);
    add_row(1'b1, OP_ADD, 16'h0025, 1'b0, 1'b0);
    add_row(1'b1, OP_SUB, 16'h0100, 1'b0, 1'b0);
    add_row(1'b1, OP_XOR, 16'hA5A5, 1'b0, 1'b0);
    add_fillers(1);
    add_row(1'b1, OP_CLR, 16'h1357, 1'b0, 1'b0);
    add_row(1'b1, OP_SUB, 16'h0001, 1'b0, 1'b0);
    add_row(1'b1, OP_ADD, 16'h0001, 1'b0, 1'b0);
    // Faults on the main accumulator and on res_valid alone
    add_row(1'b1, OP_LOAD, 16'h1234, 1'b1, 1'b0);
    add_row(1'b1, OP_ADD, 16'h0001, 1'b0, 1'b0);
    add_fillers(2);
    add_row(1'b1, OP_ADD, 16'h0010, 1'b0, 1'b1);
    add_row(1'b1, OP_XOR, 16'h00FF, 1'b0, 1'b0);
    add_row(1'b0, OP_CLR, 16'h0000, 1'b1, 1'b0);
    add_fillers(2);
    // Illegal opcodes must leave the accumulator untouched
    add_row(1'b1, OP_LOAD, 16'h00FF, 1'b0, 1'b0);
    add_row(1'b1, 3'd5, 16'h1111, 1'b0, 1'b0);
    add_row(1'b1, OP_ADD, 16'h0001, 1'b0, 1'b0);
    add_row(1'b1, 3'd6, 16'h2222, 1'b0, 1'b0);
    add_fillers(1);
    add_row(1'b1, 3'd7, 16'h3333, 1'b0, 1'b0);
    add_row(1'b1, OP_SUB, 16'h0200, 1'b0, 1'b0);
    // Random stream, about three quarters valid
    for (int i = 0; i < RANDOM_ROWS; i++) begin
      draw_bits(2, bits);
      valid = |bits[1:0];
      draw_bits(OP_W, bits);
      op = bits[OP_W-1:0];
      if (op > 3'd4) begin
        op = op - 3'd3;
      end
      draw_bits(DATA_W, operand);
      add_row(valid, op, operand, 1'b0, 1'b0);
    end
  endtask

  //////////////////////////////////////////////////
  // Main core model and checks
  //////////////////////////////////////////////////

  task automatic main_core_step(input row_t row, output core_out_t out);
    out.res_valid = 1'b0;
    out.illegal   = 1'b0;
    if (row.valid && !is_legal(row.opcode)) begin
      out.illegal = 1'b1;
    end else if (row.valid) begin
      case (op_e'(row.opcode))
        OP_CLR:  main_acc = '0;
        OP_LOAD: main_acc = row.operand;
        OP_ADD:  main_acc = main_acc + row.operand;
        OP_SUB:  main_acc = main_acc - row.operand;
        default: main_acc = main_acc ^ row.operand;
      endcase
      out.res_valid = 1'b1;
    end
    out.acc = main_acc;
  endtask

  task automatic fail_run();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_alerts(input logic exp_major, input logic exp_minor);
    assert (alert_major === exp_major) else begin
      $display("error: %0t alert_major_o expected %0b actual %0b",
               $time, exp_major, alert_major);
      fail_run();
    end
    assert (alert_minor === exp_minor) else begin
      $display("error: %0t alert_minor_o expected %0b actual %0b",
               $time, exp_minor, alert_minor);
      fail_run();
    end
  endtask

  function automatic logic pipe_busy();
    logic busy;
    busy = 1'b0;
    for (int i = 0; i < OUTPUTS_OFFSET; i++) begin
      busy = busy | pipe_q[i].valid;
    end
    return busy;
  endfunction

  // One cycle: check alerts, answer the previous row, present the next one
  task automatic run_cycle(input row_t next_row, input logic next_real);
    core_out_t out;
    exp_t      entry;
    @(negedge clk);
    check_alerts(pipe_q[0].major, pipe_q[0].minor);
    main_core_step(cur_row, out);
    if (cur_row.corrupt_acc) begin
      out.acc[CORRUPT_BIT] = ~out.acc[CORRUPT_BIT];
    end
    if (cur_row.corrupt_valid) begin
      out.res_valid = ~out.res_valid;
    end
    core_out    = out;
    entry.valid = cur_real;
    entry.major = cur_row.exp_major;
    entry.minor = cur_row.exp_minor;
    for (int i = 0; i < OUTPUTS_OFFSET - 1; i++) begin
      pipe_q[i] = pipe_q[i+1];
    end
    pipe_q[OUTPUTS_OFFSET-1] = entry;
    core_in.instr_valid      = next_row.valid;
    core_in.opcode           = op_e'(next_row.opcode);
    core_in.operand          = next_row.operand;
    cur_row                  = next_row;
    cur_real                 = next_real;
  endtask

  //////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////

  task automatic apply_reset();
    core_out_t fault;
    fault           = '0;
    fault.res_valid = 1'b1;
    fault.acc       = 16'hDEAD;
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge clk);
      check_alerts(1'b0, 1'b0);
      // Sampled by the last edge in reset, before comparison starts
      if (i == RESET_CYCLES - 2) begin
        core_out = fault;
      end else begin
        core_out = '0;
      end
    end
    rst_n = 1'b1;
  endtask

  task automatic drain_pipeline();
    row_t idle;
    int   cycles;
    idle   = '0;
    cycles = 0;
    while (cur_real || pipe_busy()) begin
      if (cycles >= DRAIN_TIMEOUT) begin
        $display("Timed out waiting for the expected alerts to drain");
        fail_run();
      end else begin
        run_cycle(idle, 1'b0);
        cycles++;
      end
    end
  endtask

  initial begin
    rst_n    = 1'b0;
    core_in  = '0;
    core_out = '0;
    main_acc = '0;
    lfsr_q   = LFSR_SEED;
    cur_row  = '0;
    cur_real = 1'b0;
    for (int i = 0; i < OUTPUTS_OFFSET; i++) begin
      pipe_q[i] = '0;
    end
    build_table();
    apply_reset();
    foreach (table_q[i]) begin
      run_cycle(table_q[i], 1'b1);
    end
    drain_pipeline();
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/accum_core.sv
// Small accumulator core, used here as the shadow copy of the main core.
// On each valid instruction the accumulator is updated per the opcode and
// the result flags are registered. Illegal opcodes leave the accumulator alone.

`timescale 1ns/1ps
`default_nettype none

module accum_core (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  lockstep_pkg::core_in_t  core_in_i,
  output lockstep_pkg::core_out_t core_out_o
);

  import lockstep_pkg::*;

  logic [DATA_W-1:0] acc_d, acc_q;
  logic              legal;
  logic              res_valid_q;
  logic              illegal_q;

  //////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////

  always_comb begin
    acc_d = acc_q;
    legal = 1'b1;
    unique case (core_in_i.opcode)
      OP_CLR:  acc_d = '0;
      OP_LOAD: acc_d = core_in_i.operand;
      // Add and subtract wrap modulo 2^DATA_W
      OP_ADD:  acc_d = acc_q + core_in_i.operand;
      OP_SUB:  acc_d = acc_q - core_in_i.operand;
      OP_XOR:  acc_d = acc_q ^ core_in_i.operand;
      default: legal = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // State and output registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q       <= '0;
      res_valid_q <= 1'b0;
      illegal_q   <= 1'b0;
    end else if (core_in_i.instr_valid) begin
      if (legal) begin
        acc_q <= acc_d;
      end
      res_valid_q <= legal;
      illegal_q   <= ~legal;
    end else begin
      res_valid_q <= 1'b0;
      illegal_q   <= 1'b0;
    end
  end

  assign core_out_o.res_valid = res_valid_q;
  assign core_out_o.illegal   = illegal_q;
  assign core_out_o.acc       = acc_q;

endmodule

`default_nettype wire

// File: rtl/input_delay_line.sv
// Input delay for the shadow core.
// Shifts the inputs seen by the main core through LOCKSTEP_OFFSET stages so
// the shadow core executes the same history, delayed.

`timescale 1ns/1ps
`default_nettype none

module input_delay_line (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  lockstep_pkg::core_in_t core_in_i,
  output lockstep_pkg::core_in_t shadow_in_o
);

  import lockstep_pkg::*;

  // Entry LOCKSTEP_OFFSET-1 is the newest, entry 0 the oldest
  core_in_t [LOCKSTEP_OFFSET-1:0] stage_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= '0;
    end else begin
      for (int unsigned i = 0; i < LOCKSTEP_OFFSET - 1; i++) begin
        stage_q[i] <= stage_q[i+1];
      end
      stage_q[LOCKSTEP_OFFSET-1] <= core_in_i;
    end
  end

  assign shadow_in_o = stage_q[0];

endmodule

`default_nettype wire

// File: rtl/lockstep_pkg.sv
// Shared definitions for the lockstep checker.
// Holds the lockstep offsets, datapath widths, the opcode encoding and
// the structs carrying the core inputs and outputs between blocks.

`default_nettype none

package lockstep_pkg;

  //////////////////////////////////////////////////
  // Offsets and widths
  //////////////////////////////////////////////////

  // Shadow core runs this many cycles behind the main core
  localparam int unsigned LOCKSTEP_OFFSET = 2;
  // One extra cycle for the shadow output register
  localparam int unsigned OUTPUTS_OFFSET  = LOCKSTEP_OFFSET + 1;
  localparam int unsigned OFFSET_CNT_W    = (LOCKSTEP_OFFSET > 1) ? $clog2(LOCKSTEP_OFFSET) : 1;

  localparam int unsigned DATA_W = 16;
  localparam int unsigned OP_W   = 3;

  //////////////////////////////////////////////////
  // Opcodes and structs
  //////////////////////////////////////////////////

  // Codes 5 to 7 are illegal
  typedef enum logic [OP_W-1:0] {
    OP_CLR  = 3'd0,
    OP_LOAD = 3'd1,
    OP_ADD  = 3'd2,
    OP_SUB  = 3'd3,
    OP_XOR  = 3'd4
  } op_e;

  typedef struct packed {
    logic              instr_valid;
    op_e               opcode;
    logic [DATA_W-1:0] operand;
  } core_in_t;

  typedef struct packed {
    logic              res_valid;
    logic              illegal;
    logic [DATA_W-1:0] acc;
  } core_out_t;

endpackage

`default_nettype wire

// File: rtl/lockstep_top.sv
// Top level of the dual-core lockstep checker.
// Takes the inputs and outputs of an external main core, replays the inputs
// into a delayed shadow accumulator core and raises an alert on divergence.
// alert_minor_o flags an illegal opcode seen by the shadow core.

`timescale 1ns/1ps
`default_nettype none

module lockstep_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  lockstep_pkg::core_in_t  core_in_i,
  input  lockstep_pkg::core_out_t core_out_i,
  output logic                   alert_major_o,
  output logic                   alert_minor_o
);

  import lockstep_pkg::*;

  logic      shadow_rst_n;
  logic      cmp_en;
  core_in_t  shadow_in;
  core_out_t shadow_out;

  //////////////////////////////////////////////////
  // Reset sequencing
  //////////////////////////////////////////////////

  shadow_reset_ctrl u_reset_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .shadow_rst_no(shadow_rst_n),
    .cmp_en_o     (cmp_en)
  );

  //////////////////////////////////////////////////
  // Input side and shadow core
  //////////////////////////////////////////////////

  input_delay_line u_input_delay (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .core_in_i  (core_in_i),
    .shadow_in_o(shadow_in)
  );

  // Shadow core runs on the sequenced reset
  accum_core u_shadow_core (
    .clk_i     (clk_i),
    .rst_ni    (shadow_rst_n),
    .core_in_i (shadow_in),
    .core_out_o(shadow_out)
  );

  //////////////////////////////////////////////////
  // Output side
  //////////////////////////////////////////////////

  output_compare u_output_compare (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmp_en_i     (cmp_en),
    .core_out_i   (core_out_i),
    .shadow_out_i (shadow_out),
    .alert_major_o(alert_major_o),
    .alert_minor_o(alert_minor_o)
  );

endmodule

`default_nettype wire

// File: rtl/output_compare.sv
// Output side of the lockstep checker.
// Delays the main core outputs by OUTPUTS_OFFSET cycles, registers the
// shadow core outputs once and compares the two when comparison is enabled.

`timescale 1ns/1ps
`default_nettype none

module output_compare (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   cmp_en_i,
  input  lockstep_pkg::core_out_t core_out_i,
  input  lockstep_pkg::core_out_t shadow_out_i,
  output logic                   alert_major_o,
  output logic                   alert_minor_o
);

  import lockstep_pkg::*;

  // Entry OUTPUTS_OFFSET-1 is the newest main output
  core_out_t [OUTPUTS_OFFSET-1:0] main_q;
  core_out_t                      shadow_q;
  logic                           mismatch;

  //////////////////////////////////////////////////
  // Main output delay
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      main_q <= '0;
    end else begin
      for (int unsigned i = 0; i < OUTPUTS_OFFSET - 1; i++) begin
        main_q[i] <= main_q[i+1];
      end
      main_q[OUTPUTS_OFFSET-1] <= core_out_i;
    end
  end

  //////////////////////////////////////////////////
  // Shadow output register
  //////////////////////////////////////////////////

  // Cleared in reset so no alert can fire before the shadow runs
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_q <= '0;
    end else begin
      shadow_q <= shadow_out_i;
    end
  end

  // Compare the aligned outputs
  assign mismatch      = (shadow_q != main_q[0]);
  assign alert_major_o = cmp_en_i & mismatch;
  assign alert_minor_o = shadow_q.illegal;

endmodule

`default_nettype wire

// File: rtl/shadow_reset_ctrl.sv
// Reset sequencing for the shadow core.
// Holds the shadow core in reset for LOCKSTEP_OFFSET cycles after the
// main reset is released, then enables the output comparison one cycle later.

`timescale 1ns/1ps
`default_nettype none

module shadow_reset_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  output logic shadow_rst_no,
  output logic cmp_en_o
);

  import lockstep_pkg::*;

  logic [OFFSET_CNT_W-1:0] cnt_d, cnt_q;
  logic                    rst_set_d, rst_set_q;
  logic                    cmp_en_q;

  // Counter saturates once the offset has elapsed
  assign rst_set_d = (cnt_q == OFFSET_CNT_W'(LOCKSTEP_OFFSET - 1));
  assign cnt_d     = rst_set_d ? cnt_q : (cnt_q + OFFSET_CNT_W'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q     <= '0;
      rst_set_q <= 1'b0;
      cmp_en_q  <= 1'b0;
    end else begin
      cnt_q     <= cnt_d;
      // Shadow reset released synchronously
      rst_set_q <= rst_set_d;
      // Compare starts the cycle after release
      cmp_en_q  <= rst_set_q;
    end
  end

  assign shadow_rst_no = rst_set_q;
  assign cmp_en_o      = cmp_en_q;

endmodule

`default_nettype wire
